// ==== hdl/dual_port_ram.sv ====
`timescale 1ns/100ps

module dual_port_ram #(
	parameter int addr_width = 3
) (
	input logic clk,
	input logic wr_en,
	input logic [addr_width-1:0] wr_addr,
	input lane_item_pkg::lane_item_t wr_data,
	input logic rd_en,
	input logic [addr_width-1:0] rd_addr,
	output lane_item_pkg::lane_item_t rd_data
);

	import lane_item_pkg::*;

	localparam int depth = 1 << addr_width;

	lane_item_t mem [depth];	// Storage array

	// Synchronous write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read port, data valid the cycle after the strobe
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// ==== hdl/fifo.sv ====
`timescale 1ns/100ps

module fifo #(
	parameter int addr_width = 3
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input lane_item_pkg::lane_item_t wr_item,
	input logic rd_en,
	output lane_item_pkg::lane_item_t rd_item,
	output logic full,
	output logic empty
);

	localparam int depth = 1 << addr_width;

	logic [addr_width-1:0] wr_ptr;		// Next slot to write
	logic [addr_width-1:0] rd_ptr;		// Next slot to read
	logic [addr_width:0] count;		// Occupancy, one bit wider than the address

	// Write pointer, wraps at depth
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// Read pointer
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
		end else if (rd_en) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Simultaneous read and write leaves the count alone
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
		end else if (wr_en && !rd_en) begin
			count <= count + 1'b1;
		end else if (rd_en && !wr_en) begin
			count <= count - 1'b1;
		end
	end

	assign full = (count == depth[addr_width:0]);	// Whole depth in use
	assign empty = (count == '0);

	// Read port output is the popped item from the cycle after rd_en
	dual_port_ram #(
		.addr_width(addr_width)
	) u_dual_port_ram (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_ptr),
		.wr_data(wr_item),
		.rd_en(rd_en),
		.rd_addr(rd_ptr),
		.rd_data(rd_item)
	);

	// Dispatcher must hold off a full lane
	a_no_write_when_full: assert property (
		@(posedge clk) disable iff (rst) full |-> !wr_en
	) else $error("fifo write while full");

	// Collector must only pop a lane that holds data
	a_no_read_when_empty: assert property (
		@(posedge clk) disable iff (rst) empty |-> !rd_en
	) else $error("fifo read while empty");

endmodule

// ==== hdl/lane_buffer_top.sv ====
`timescale 1ns/100ps

module lane_buffer_top #(
	parameter int lane_count = 4,
	parameter int addr_width = 3
) (
	input logic clk,
	input logic rst,
	input logic in_req,
	output logic in_ack,
	input lane_item_pkg::lane_item_t in_item,
	output logic out_req,
	input logic out_ack,
	output lane_item_pkg::lane_item_t out_item
);

	import lane_item_pkg::*;

	logic [lane_count-1:0] wr_en;		// Per-lane write strobes
	lane_item_t wr_item;			// Shared write data
	logic [lane_count-1:0] full;
	logic [lane_count-1:0] rd_en;		// Per-lane pops
	lane_item_t rd_item [lane_count];	// Per-lane read data
	logic [lane_count-1:0] empty;

	lane_dispatcher #(
		.lane_count(lane_count)
	) u_lane_dispatcher (
		.clk(clk),
		.rst(rst),
		.in_req(in_req),
		.in_ack(in_ack),
		.in_item(in_item),
		.wr_en(wr_en),
		.wr_item(wr_item),
		.full(full)
	);

	// One FIFO per lane
	for (genvar i = 0; i < lane_count; i++) begin : g_lane
		fifo #(
			.addr_width(addr_width)
		) u_fifo (
			.clk(clk),
			.rst(rst),
			.wr_en(wr_en[i]),
			.wr_item(wr_item),
			.rd_en(rd_en[i]),
			.rd_item(rd_item[i]),
			.full(full[i]),
			.empty(empty[i])
		);
	end

	lane_collector #(
		.lane_count(lane_count)
	) u_lane_collector (
		.clk(clk),
		.rst(rst),
		.empty(empty),
		.rd_en(rd_en),
		.rd_item(rd_item),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_item(out_item)
	);

endmodule

// ==== hdl/lane_collector.sv ====
`timescale 1ns/100ps

module lane_collector #(
	parameter int lane_count = 4
) (
	input logic clk,
	input logic rst,
	input logic [lane_count-1:0] empty,
	output logic [lane_count-1:0] rd_en,
	input lane_item_pkg::lane_item_t rd_item [lane_count],
	output logic out_req,
	input logic out_ack,
	output lane_item_pkg::lane_item_t out_item
);

	import lane_item_pkg::*;
	import lane_ctrl_pkg::*;

	coll_state_e state;
	logic [lane_id_width-1:0] last_lane;	// Lane of the last finished packet
	logic [lane_id_width-1:0] cur_lane;	// Lane being drained
	logic in_packet;			// Mid-packet lock to cur_lane
	logic [lane_id_width-1:0] pick_lane;
	logic pick_found;

	// Round-robin choice at packet boundaries only
	always_comb begin
		int idx;
		idx = 0;
		pick_found = 1'b0;
		pick_lane = cur_lane;
		if (in_packet) begin
			pick_found = !empty[cur_lane];	// Wait on the same lane
		end else begin
			// Descending so the nearest lane after last_lane wins
			for (int k = lane_count; k >= 1; k--) begin
				idx = (int'(last_lane) + k) % lane_count;
				if (!empty[idx]) begin
					pick_found = 1'b1;
					pick_lane = lane_id_width'(idx);
				end
			end
		end
	end

	always_comb begin
		rd_en = '0;
		if (state == coll_pick && pick_found) begin
			rd_en[pick_lane] = 1'b1;	// Single-cycle pop
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= coll_pick;
			last_lane <= lane_id_width'(lane_count - 1);	// Lane 0 goes first
			cur_lane <= '0;
			in_packet <= 1'b0;
			out_req <= 1'b0;
		end else begin
			case (state)
				coll_pick: begin
					if (pick_found) begin
						cur_lane <= pick_lane;
						state <= coll_read;
					end
				end
				coll_read: begin
					out_req <= 1'b1;	// RAM data is in out_item now
					state <= coll_req;
				end
				coll_req: begin
					if (out_ack) begin
						out_req <= 1'b0;
						state <= coll_release;
					end
				end
				coll_release: begin
					if (!out_ack) begin
						if (out_item.kind == kind_mark) begin
							last_lane <= cur_lane;
							in_packet <= 1'b0;
						end else begin
							in_packet <= 1'b1;
						end
						state <= coll_pick;
					end
				end
				default: state <= coll_pick;
			endcase
		end
	end

	// Output payload register
	always_ff @(posedge clk) begin
		if (state == coll_read) begin
			out_item <= rd_item[cur_lane];
		end
	end

	a_out_item_stable: assert property (
		@(posedge clk) disable iff (rst) out_req && $past(out_req) |-> $stable(out_item)
	) else $error("out_item changed while out_req high");

endmodule

// ==== hdl/lane_ctrl_pkg.sv ====
package lane_ctrl_pkg;

	// Input side four-phase receiver
	typedef enum logic [1:0] {
		disp_idle = 2'd0,	// Waiting for req
		disp_ack = 2'd1		// Ack high, waiting for req to fall
	} disp_state_e;

	// Output side packet drain and four-phase sender
	typedef enum logic [2:0] {
		coll_pick = 3'd0,	// Choosing a lane
		coll_read = 3'd1,	// Read issued, RAM data pending
		coll_req = 3'd2,	// out_req high, waiting for ack
		coll_release = 3'd3	// out_req low, waiting for ack to fall
	} coll_state_e;

endpackage

// ==== hdl/lane_dispatcher.sv ====
`timescale 1ns/100ps

module lane_dispatcher #(
	parameter int lane_count = 4
) (
	input logic clk,
	input logic rst,
	input logic in_req,
	output logic in_ack,
	input lane_item_pkg::lane_item_t in_item,
	output logic [lane_count-1:0] wr_en,
	output lane_item_pkg::lane_item_t wr_item,
	input logic [lane_count-1:0] full
);

	import lane_ctrl_pkg::*;

	disp_state_e state;
	logic [lane_count-1:0] lane_sel;	// One-hot target lane of in_item
	logic accept;				// Item can go into its lane this cycle

	always_comb begin
		lane_sel = '0;
		lane_sel[in_item.lane] = 1'b1;
	end

	assign accept = (state == disp_idle) && in_req && !full[in_item.lane];

	// Handshake FSM, wr_en pulses once per accepted item
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= disp_idle;
			in_ack <= 1'b0;
			wr_en <= '0;
		end else begin
			wr_en <= '0;
			case (state)
				disp_idle: begin
					if (accept) begin
						wr_en <= lane_sel;
						in_ack <= 1'b1;
						state <= disp_ack;
					end
				end
				disp_ack: begin
					if (!in_req) begin	// Return to zero
						in_ack <= 1'b0;
						state <= disp_idle;
					end
				end
				default: begin
					in_ack <= 1'b0;
					state <= disp_idle;
				end
			endcase
		end
	end

	// Item is captured together with the strobe
	always_ff @(posedge clk) begin
		if (accept) begin
			wr_item <= in_item;
		end
	end

	// A lane number past the lane count is a sender error
	a_lane_in_range: assert property (
		@(posedge clk) disable iff (rst) in_req |-> (in_item.lane < lane_count)
	) else $error("item lane %0d out of range", in_item.lane);

	// Only one FIFO is written per cycle
	a_wr_en_onehot: assert property (
		@(posedge clk) disable iff (rst) $onehot0(wr_en)
	) else $error("more than one lane written");

endmodule

// ==== hdl/lane_item_pkg.sv ====
package lane_item_pkg;

	// Lane field width, room for up to four lanes
	parameter int lane_id_width = 2;

	// Payload carried by every item
	parameter int payload_width = 16;

	// Item kind, a packet is a run of data items closed by a mark
	typedef enum logic {
		kind_data = 1'b0,	// Item inside a packet
		kind_mark = 1'b1	// Last item of a packet
	} item_kind_e;

	// One item as it travels through the lane buffer, 19 bits
	typedef struct packed {
		logic [lane_id_width-1:0] lane;		// Destination lane
		item_kind_e kind;			// Data or mark
		logic [payload_width-1:0] payload;	// User data
	} lane_item_t;

endpackage

// ==== tb.f ====
hdl/lane_item_pkg.sv
hdl/lane_ctrl_pkg.sv
hdl/dual_port_ram.sv
hdl/fifo.sv
hdl/lane_dispatcher.sv
hdl/lane_collector.sv
hdl/lane_buffer_top.sv
test/tb_lane_buffer.sv

// ==== test/tb_lane_buffer.sv ====
`timescale 1ns/100ps

module tb_lane_buffer;

	import lane_item_pkg::*;

	localparam int lane_count = 4;
	localparam int addr_width = 3;
	localparam int hs_limit = 4000;	// Cycles allowed for one handshake phase

	logic clk;
	logic rst;
	logic in_req;
	logic in_ack;
	lane_item_t in_item;
	logic out_req;
	logic out_ack;
	lane_item_t out_item;

	lane_item_t stim_q[$];			// Items still to be sent
	lane_item_t model_q[lane_count][$];	// Expected output per lane
	int errors;
	int checks;
	string cur_test;
	int ack_min;				// Receiver ack delay range
	int ack_max;
	int max_ack_wait;			// Longest in_ack wait of the current run
	logic in_pkt;				// Output is inside a packet
	logic [lane_id_width-1:0] pkt_lane;	// Lane of that packet

	lane_buffer_top #(
		.lane_count(lane_count),
		.addr_width(addr_width)
	) u_lane_buffer_top (
		.clk(clk),
		.rst(rst),
		.in_req(in_req),
		.in_ack(in_ack),
		.in_item(in_item),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_item(out_item)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_on_timeout(input string what);
		errors++;
		$display("timeout in %s: %s", cur_test, what);
		$display("checks %0d, errors %0d", checks, errors);
		$display("tests failed");
		$finish;
	endtask

	task automatic check_idle_outputs();
		checks++;
		if (in_ack !== 1'b0) begin
			errors++;
			$display("error reset_state: expected in_ack 0, actual %b", in_ack);
		end
		if (out_req !== 1'b0) begin
			errors++;
			$display("error reset_state: expected out_req 0, actual %b", out_req);
		end
	endtask

	// Random packets, each a run of data items closed by a mark
	task automatic make_packets(input int n, input int fixed_lane, input int min_len,
			input int max_len);
		int len;
		lane_item_t item;
		for (int p = 0; p < n; p++) begin
			len = min_len + ($urandom % (max_len - min_len + 1));
			if (fixed_lane < 0) begin
				item.lane = lane_id_width'($urandom % lane_count);
			end else begin
				item.lane = lane_id_width'(fixed_lane);
			end
			for (int i = 0; i < len; i++) begin
				item.kind = (i == len - 1) ? kind_mark : kind_data;
				item.payload = payload_width'($urandom);
				stim_q.push_back(item);
			end
		end
	endtask

	// Four-phase send, called just after a falling edge
	task automatic send_item(input lane_item_t item);
		int cnt;
		in_item = item;
		in_req = 1'b1;
		cnt = 0;
		@(negedge clk);
		while (!in_ack) begin
			if (cnt == hs_limit) begin
				abort_on_timeout("in_ack never rose for a pending input item");
			end
			cnt++;
			@(negedge clk);
		end
		if (cnt > max_ack_wait) begin
			max_ack_wait = cnt;
		end
		model_q[item.lane].push_back(item);	// Accepted, now expected at the output
		in_req = 1'b0;
		cnt = 0;
		@(negedge clk);
		while (in_ack) begin
			if (cnt == hs_limit) begin
				abort_on_timeout("in_ack stayed high after in_req fell");
			end
			cnt++;
			@(negedge clk);
		end
	endtask

	task automatic send_all();
		lane_item_t item;
		while (stim_q.size() > 0) begin
			item = stim_q.pop_front();
			send_item(item);
			repeat ($urandom % 3) @(negedge clk);	// Idle gap
		end
	endtask

	task automatic check_item(input lane_item_t got);
		lane_item_t exp;
		checks++;
		if (in_pkt && got.lane != pkt_lane) begin
			errors++;
			$display("error packet_integrity: expected lane %0d, actual lane %0d",
				pkt_lane, got.lane);
		end
		if (model_q[got.lane].size() == 0) begin
			errors++;
			$display("%s: item %h came out of lane %0d, which had nothing outstanding",
				cur_test, got, got.lane);
		end else begin
			exp = model_q[got.lane].pop_front();
			if (got != exp) begin
				errors++;
				$display("error %s: expected %h, actual %h", cur_test, exp, got);
			end
		end
		in_pkt = (got.kind != kind_mark);
		pkt_lane = got.lane;
	endtask

	// Four-phase receive with a random ack delay
	task automatic receive_item();
		int cnt;
		int delay;
		cnt = 0;
		while (!out_req) begin
			if (cnt == hs_limit) begin
				abort_on_timeout("out_req never rose while items were outstanding");
			end
			cnt++;
			@(negedge clk);
		end
		check_item(out_item);
		delay = ack_min + ($urandom % (ack_max - ack_min + 1));
		repeat (delay) @(negedge clk);
		out_ack = 1'b1;
		cnt = 0;
		@(negedge clk);
		while (out_req) begin
			if (cnt == hs_limit) begin
				abort_on_timeout("out_req stayed high after out_ack rose");
			end
			cnt++;
			@(negedge clk);
		end
		out_ack = 1'b0;
	endtask

	task automatic check_drained();
		for (int l = 0; l < lane_count; l++) begin
			if (model_q[l].size() != 0) begin
				errors++;
				$display("%s: lane %0d still holds %0d items that never came out",
					cur_test, l, model_q[l].size());
			end
		end
		// Nothing more may appear once every item is out
		repeat (10) begin
			@(negedge clk);
			if (out_req) begin
				errors++;
				$display("%s: out_req rose with no item outstanding", cur_test);
			end
		end
	endtask

	task automatic run_traffic(input string name, input int amin, input int amax);
		int total;
		cur_test = name;
		ack_min = amin;
		ack_max = amax;
		max_ack_wait = 0;
		total = stim_q.size();
		fork
			send_all();
			repeat (total) receive_item();
		join
		check_drained();
	endtask

	initial begin
		void'($urandom(32'h0e03_c1f9));
		rst = 1'b1;
		in_req = 1'b0;
		in_item = '0;
		out_ack = 1'b0;
		errors = 0;
		checks = 0;
		in_pkt = 1'b0;
		pkt_lane = '0;
		ack_min = 0;
		ack_max = 0;
		max_ack_wait = 0;
		cur_test = "reset_state";
		repeat (16) begin
			@(negedge clk);
			check_idle_outputs();
		end
		rst = 1'b0;
		repeat (4) begin
			@(negedge clk);
			check_idle_outputs();	// Still idle right after reset
		end

		make_packets(20, 0, 1, 5);
		run_traffic("single_lane_order", 0, 3);

		make_packets(60, -1, 1, 6);
		run_traffic("multi_lane_order", 0, 4);

		make_packets(30, -1, 3, 10);	// Long packets, some past the lane depth
		run_traffic("packet_integrity", 0, 1);

		// Slow receiver, more than eight items into lane 2
		make_packets(2, 2, 10, 12);
		run_traffic("back_pressure", 30, 60);
		checks++;
		if (max_ack_wait < 20) begin
			errors++;
			$display("back_pressure: lane never filled, longest in_ack wait was %0d cycles",
				max_ack_wait);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
